/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_sb_core
RTL_TOP   ?= sb_core
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
LINT_SRCS ?= src/sb_pkg.sv src/inst_decoder.sv src/scoreboard.sv \
             src/alu_unit.sv src/reg_file.sv src/sb_core.sv
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall $(LINT_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
src/sb_pkg.sv
src/inst_decoder.sv
src/scoreboard.sv
src/alu_unit.sv
src/reg_file.sv
src/sb_core.sv
sim/sb_core_props.sv
sim/sb_checker.sv
sim/tb_sb_core.sv

/* sim/sb_checker.sv */
`timescale 1ns/10ps

module sb_checker import sb_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  word_t                inst,
	input  logic                 inst_valid,
	input  logic                 inst_ready,
	input  logic [num_units-1:0] wb_valid,
	input  reg_idx_t             wb_dest_0,
	input  word_t                wb_value_0,
	input  reg_idx_t             wb_dest_1,
	input  word_t                wb_value_1,
	input  reg_idx_t             dbg_addr,
	input  word_t                dbg_value,
	input  logic                 dbg_check,
	input  logic                 idle,
	output int                   err_count,
	output int                   unexp_count,
	output int                   wb_count
);

	// architectural state in program order
	word_t    model    [num_regs];
	// results still to come back, oldest first
	word_t    expect_q [num_regs][$];
	word_t    res;
	reg_idx_t dst;

	function automatic logic model_exec(input word_t w, output word_t v);
		opcode_t opc;
		word_t   a;
		word_t   b;
		word_t   imm;
		logic    known;
		opc   = w[opc_hi:opc_lo];
		a     = model[w[src_a_hi:src_a_lo]];
		b     = model[w[src_b_hi:src_b_lo]];
		// two's complement field, negative when its top bit is set
		imm   = word_t'(w[imm_hi:imm_lo]);
		if (w[imm_hi])
			imm = imm - word_t'(1 << imm_w);
		known = 1'b1;
		case (opc)
			opc_addi: v = a + imm;
			opc_add:  v = a + b;
			opc_subi: v = a - imm;
			opc_sub:  v = a - b;
			default: begin
				v     = '0;
				known = 1'b0;
			end
		endcase
		return known;
	endfunction

	task automatic check_wb(input int u, input reg_idx_t d, input word_t v);
		word_t e;
		wb_count++;
		if (expect_q[d].size() == 0) begin
			$display("unit %0d wrote r%0d with no instruction outstanding for it", u, d);
			unexp_count++;
		end else begin
			e = expect_q[d].pop_front();
			if (v !== e) begin
				$display("FAILED wb_value_%0d: r%0d got %h, expected %h", u, d, v, e);
				err_count++;
			end
		end
	endtask

	always @(posedge clk) begin
		if (!arst_n) begin
			for (int r = 0; r < num_regs; r++) begin
				model[r] = '0;
				expect_q[r].delete();
			end
			err_count   = 0;
			unexp_count = 0;
			wb_count    = 0;
		end else begin
			// pops before pushes since a register may retire and refill in one cycle
			if (wb_valid[0])
				check_wb(0, wb_dest_0, wb_value_0);
			if (wb_valid[1])
				check_wb(1, wb_dest_1, wb_value_1);
			if (inst_valid && inst_ready) begin
				if (model_exec(inst, res)) begin
					dst        = inst[dest_hi:dest_lo];
					model[dst] = res;
					expect_q[dst].push_back(res);
				end
			end
			if (dbg_check) begin
				if (dbg_value !== model[dbg_addr]) begin
					$display("FAILED dbg_value: r%0d got %h, expected %h",
						dbg_addr, dbg_value, model[dbg_addr]);
					err_count++;
				end
				if (!idle) begin
					$display("core was not idle during the register read-back");
					err_count++;
				end
				if (expect_q[dbg_addr].size() != 0) begin
					$display("r%0d still waits for %0d writebacks",
						dbg_addr, expect_q[dbg_addr].size());
					err_count++;
				end
			end
		end
	end

endmodule

/* sim/sb_core_props.sv */
`timescale 1ns/10ps

module sb_core_props import sb_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  word_t                inst,
	input  logic                 inst_valid,
	input  logic                 inst_ready,
	input  logic                 idle,
	input  logic [num_units-1:0] wb_valid,
	input  reg_idx_t             wb_dest_0,
	input  reg_idx_t             wb_dest_1
);

	int idle_fails = 0;
	int wb_fails   = 0;
	int hold_fails = 0;

	// empty hold stage always takes an instruction
	idle_ready: assert property (@(posedge clk) disable iff (!arst_n)
		idle |-> inst_ready)
		else begin
			$error("inst_ready low while the core is idle");
			idle_fails++;
		end

	// WAW stall keeps the two write ports apart
	wb_distinct: assert property (@(posedge clk) disable iff (!arst_n)
		!(wb_valid[0] && wb_valid[1] && (wb_dest_0 == wb_dest_1)))
		else begin
			$error("both units wrote register %0d in one cycle", wb_dest_0);
			wb_fails++;
		end

	inst_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(inst_valid && !inst_ready) |=> (inst_valid && $stable(inst)))
		else begin
			$error("instruction changed or dropped while stalled");
			hold_fails++;
		end

endmodule

bind sb_core sb_core_props u_props (
	.clk(clk), .arst_n(arst_n), .inst(inst), .inst_valid(inst_valid),
	.inst_ready(inst_ready), .idle(idle), .wb_valid(wb_valid),
	.wb_dest_0(wb_dest_0), .wb_dest_1(wb_dest_1)
);

/* sim/tb_sb_core.sv */
`timescale 1ns/10ps

module tb_sb_core import sb_pkg::*; ();

	localparam int num_insts  = 400;
	localparam int max_cycles = num_insts * 12 + 200;

	logic                 clk;
	logic                 arst_n;
	word_t                inst;
	logic                 inst_valid;
	logic                 inst_ready;
	reg_idx_t             dbg_addr;
	word_t                dbg_value;
	logic [num_units-1:0] wb_valid;
	reg_idx_t             wb_dest_0;
	word_t                wb_value_0;
	reg_idx_t             wb_dest_1;
	word_t                wb_value_1;
	logic                 idle;
	logic                 dbg_check;

	int          seed;
	logic [31:0] rnd;
	word_t       next_inst;
	int          cycles = 0;
	int          err_count;
	int          unexp_count;
	int          wb_count;
	int          known_sent;
	int          other_errs;
	int          assert_fails;

	sb_core DUT (
		.clk(clk), .arst_n(arst_n), .inst(inst), .inst_valid(inst_valid),
		.inst_ready(inst_ready), .dbg_addr(dbg_addr), .dbg_value(dbg_value),
		.wb_valid(wb_valid), .wb_dest_0(wb_dest_0), .wb_value_0(wb_value_0),
		.wb_dest_1(wb_dest_1), .wb_value_1(wb_value_1), .idle(idle)
	);

	sb_checker u_chk (
		.clk(clk), .arst_n(arst_n), .inst(inst), .inst_valid(inst_valid),
		.inst_ready(inst_ready), .wb_valid(wb_valid), .wb_dest_0(wb_dest_0),
		.wb_value_0(wb_value_0), .wb_dest_1(wb_dest_1), .wb_value_1(wb_value_1),
		.dbg_addr(dbg_addr), .dbg_value(dbg_value), .dbg_check(dbg_check), .idle(idle),
		.err_count(err_count), .unexp_count(unexp_count), .wb_count(wb_count)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == max_cycles) begin
			$display("run stopped after %0d cycles without draining", max_cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// roughly one in sixteen gets an unknown opcode
	function automatic word_t make_inst(input logic [31:0] r);
		opcode_t opc;
		if (r[31:28] == 4'hf)
			opc = 5'd4 + {1'b0, r[27:24]};
		else
			opc = {3'b000, r[17:16]};
		return {opc, r[10:0]};
	endfunction

	// holds the instruction until the core takes it
	task automatic send_inst(input word_t w);
		@(negedge clk);
		inst       = w;
		inst_valid = 1'b1;
		while (!inst_ready)
			@(negedge clk);
		@(posedge clk);
	endtask

	task automatic idle_gap(input int n);
		repeat (n) begin
			@(negedge clk);
			inst_valid = 1'b0;
		end
	endtask

	task automatic read_all_regs;
		for (int r = 0; r < num_regs; r++) begin
			@(negedge clk);
			dbg_addr  = reg_idx_t'(r);
			dbg_check = 1'b1;
		end
		@(negedge clk);
		dbg_check = 1'b0;
	endtask

	task automatic wait_idle;
		@(negedge clk);
		inst_valid = 1'b0;
		while (!idle)
			@(negedge clk);
	endtask

	initial begin
		seed       = 32'h51a0a719;
		clk        = 1'b0;
		arst_n     = 1'b0;
		inst       = '0;
		inst_valid = 1'b0;
		dbg_addr   = '0;
		dbg_check  = 1'b0;
		other_errs = 0;
		known_sent = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		read_all_regs();

		for (int i = 0; i < num_insts; i++) begin
			rnd = $random(seed);
			if (rnd[2])
				idle_gap(int'(rnd[1:0]) + 1);
			rnd       = $random(seed);
			next_inst = make_inst(rnd);
			if (next_inst[opc_hi:opc_lo] inside {opc_addi, opc_add, opc_subi, opc_sub})
				known_sent++;
			send_inst(next_inst);
		end
		wait_idle();
		read_all_regs();

		// one writeback per known instruction, none for unknown opcodes
		if (wb_count != known_sent) begin
			$display("core wrote back %0d results for %0d known instructions",
				wb_count, known_sent);
			other_errs++;
		end
		assert_fails = DUT.u_props.idle_fails + DUT.u_props.wb_fails + DUT.u_props.hold_fails;
		$display("errors: %0d wrong value, %0d unexpected writeback, %0d assertion, %0d other",
			err_count, unexp_count, assert_fails, other_errs);
		if (err_count + unexp_count + assert_fails + other_errs == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* src/alu_unit.sv */
`timescale 1ns/10ps

module alu_unit import sb_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     disp_valid,
	input  alu_op_t  disp_op,
	input  reg_idx_t disp_dest,
	input  word_t    opnd_a,
	input  word_t    opnd_b,
	output logic     wb_valid,
	output reg_idx_t wb_dest,
	output word_t    wb_value
);

	alu_op_t op_q;
	word_t   a_q;
	word_t   b_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= disp_valid;
		end
	end

	// operands latched at dispatch
	always_ff @(posedge clk) begin
		if (disp_valid) begin
			op_q    <= disp_op;
			wb_dest <= disp_dest;
			a_q     <= opnd_a;
			b_q     <= opnd_b;
		end
	end

	// wraps modulo 2^16
	always_comb begin
		if (op_q == op_sub)
			wb_value = a_q - b_q;
		else
			wb_value = a_q + b_q;
	end

endmodule

/* src/inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder import sb_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  word_t    inst,
	input  logic     inst_valid,
	input  logic     issue,
	output logic     inst_ready,
	output logic     dec_valid,
	output alu_op_t  dec_op,
	output reg_idx_t dec_dest,
	output reg_idx_t dec_src_a,
	output reg_idx_t dec_src_b,
	output logic     dec_use_imm,
	output word_t    dec_imm
);

	logic    full;
	word_t   inst_q;
	opcode_t in_opc;
	opcode_t held_opc;
	logic    in_known;
	logic    accept;

	assign in_opc   = inst[opc_hi:opc_lo];
	assign in_known = (in_opc == opc_addi) || (in_opc == opc_add) ||
		(in_opc == opc_subi) || (in_opc == opc_sub);

	// slot frees up in the same cycle its instruction issues
	assign inst_ready = !full || issue;
	assign accept     = inst_valid && inst_ready;

	// unknown opcodes are taken but never held
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			full <= 1'b0;
		end else if (accept) begin
			full <= in_known;
		end else if (issue) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			inst_q <= inst;
		end
	end

	////////////////////////////////
	// field decode
	////////////////////////////////
	assign held_opc    = inst_q[opc_hi:opc_lo];
	assign dec_valid   = full;
	assign dec_dest    = inst_q[dest_hi:dest_lo];
	assign dec_src_a   = inst_q[src_a_hi:src_a_lo];
	assign dec_src_b   = inst_q[src_b_hi:src_b_lo];
	assign dec_use_imm = (held_opc == opc_addi) || (held_opc == opc_subi);
	assign dec_op      = ((held_opc == opc_sub) || (held_opc == opc_subi)) ? op_sub : op_add;

	// sign extend the 5-bit immediate
	assign dec_imm = {{(word_w - imm_w){inst_q[imm_hi]}}, inst_q[imm_hi:imm_lo]};

endmodule

/* src/reg_file.sv */
`timescale 1ns/10ps

module reg_file import sb_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic [num_units-1:0] wb_valid,
	input  reg_idx_t             wb_dest_0,
	input  reg_idx_t             wb_dest_1,
	input  word_t                wb_value_0,
	input  word_t                wb_value_1,
	input  reg_idx_t             rd_addr_a_0,
	input  reg_idx_t             rd_addr_b_0,
	input  reg_idx_t             rd_addr_a_1,
	input  reg_idx_t             rd_addr_b_1,
	input  reg_idx_t             dbg_addr,
	output word_t                rd_data_a_0,
	output word_t                rd_data_b_0,
	output word_t                rd_data_a_1,
	output word_t                rd_data_b_1,
	output word_t                dbg_value
);

	word_t    regs  [num_regs];
	reg_idx_t wdest [num_units];
	word_t    wval  [num_units];

	assign wdest[0] = wb_dest_0;
	assign wdest[1] = wb_dest_1;
	assign wval[0]  = wb_value_0;
	assign wval[1]  = wb_value_1;

	// same-cycle writeback wins over the stored value
	function automatic word_t rd_bypass(input reg_idx_t addr);
		word_t v;
		v = regs[addr];
		for (int u = 0; u < num_units; u++) begin
			if (wb_valid[u] && wdest[u] == addr)
				v = wval[u];
		end
		return v;
	endfunction

	always_comb begin
		rd_data_a_0 = rd_bypass(rd_addr_a_0);
		rd_data_b_0 = rd_bypass(rd_addr_b_0);
		rd_data_a_1 = rd_bypass(rd_addr_a_1);
		rd_data_b_1 = rd_bypass(rd_addr_b_1);
		dbg_value   = rd_bypass(dbg_addr);
	end

	// two writers never hit the same register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int r = 0; r < num_regs; r++)
				regs[r] <= '0;
		end else begin
			for (int u = 0; u < num_units; u++) begin
				if (wb_valid[u])
					regs[wdest[u]] <= wval[u];
			end
		end
	end

endmodule

/* src/sb_core.sv */
`timescale 1ns/10ps

module sb_core import sb_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  word_t                inst,
	input  logic                 inst_valid,
	output logic                 inst_ready,
	input  reg_idx_t             dbg_addr,
	output word_t                dbg_value,
	output logic [num_units-1:0] wb_valid,
	output reg_idx_t             wb_dest_0,
	output word_t                wb_value_0,
	output reg_idx_t             wb_dest_1,
	output word_t                wb_value_1,
	output logic                 idle
);

	logic     dec_valid;
	alu_op_t  dec_op;
	reg_idx_t dec_dest;
	reg_idx_t dec_src_a;
	reg_idx_t dec_src_b;
	logic     dec_use_imm;
	word_t    dec_imm;
	logic     issue;

	logic [num_units-1:0] disp_valid;
	alu_op_t  disp_op_0;
	alu_op_t  disp_op_1;
	reg_idx_t disp_dest_0;
	reg_idx_t disp_dest_1;
	reg_idx_t rd_addr_a_0;
	reg_idx_t rd_addr_b_0;
	reg_idx_t rd_addr_a_1;
	reg_idx_t rd_addr_b_1;
	word_t    rd_data_a_0;
	word_t    rd_data_b_0;
	word_t    rd_data_a_1;
	word_t    rd_data_b_1;
	word_t    opnd_a_0;
	word_t    opnd_b_0;
	word_t    opnd_a_1;
	word_t    opnd_b_1;

	inst_decoder u_dec (
		.clk, .arst_n, .inst, .inst_valid, .issue, .inst_ready,
		.dec_valid, .dec_op, .dec_dest, .dec_src_a, .dec_src_b,
		.dec_use_imm, .dec_imm
	);

	scoreboard u_sb (
		.clk, .arst_n, .dec_valid, .dec_op, .dec_dest, .dec_src_a, .dec_src_b,
		.dec_use_imm, .dec_imm, .wb_valid,
		.rd_data_a_0, .rd_data_b_0, .rd_data_a_1, .rd_data_b_1,
		.issue, .disp_valid, .disp_op_0, .disp_op_1, .disp_dest_0, .disp_dest_1,
		.rd_addr_a_0, .rd_addr_b_0, .rd_addr_a_1, .rd_addr_b_1,
		.opnd_a_0, .opnd_b_0, .opnd_a_1, .opnd_b_1, .idle
	);

	////////////////////////////////
	// execution units
	////////////////////////////////
	alu_unit u_alu_0 (
		.clk, .arst_n, .disp_valid(disp_valid[0]), .disp_op(disp_op_0),
		.disp_dest(disp_dest_0), .opnd_a(opnd_a_0), .opnd_b(opnd_b_0),
		.wb_valid(wb_valid[0]), .wb_dest(wb_dest_0), .wb_value(wb_value_0)
	);

	alu_unit u_alu_1 (
		.clk, .arst_n, .disp_valid(disp_valid[1]), .disp_op(disp_op_1),
		.disp_dest(disp_dest_1), .opnd_a(opnd_a_1), .opnd_b(opnd_b_1),
		.wb_valid(wb_valid[1]), .wb_dest(wb_dest_1), .wb_value(wb_value_1)
	);

	reg_file u_rf (
		.clk, .arst_n, .wb_valid, .wb_dest_0, .wb_dest_1, .wb_value_0, .wb_value_1,
		.rd_addr_a_0, .rd_addr_b_0, .rd_addr_a_1, .rd_addr_b_1, .dbg_addr,
		.rd_data_a_0, .rd_data_b_0, .rd_data_a_1, .rd_data_b_1, .dbg_value
	);

endmodule

/* src/sb_pkg.sv */
package sb_pkg;

	////////////////////////////////
	// widths and counts
	////////////////////////////////
	localparam int word_w    = 16;
	localparam int num_regs  = 8;
	localparam int num_units = 2;

	typedef logic [word_w-1:0]            word_t;
	typedef logic [$clog2(num_regs)-1:0]  reg_idx_t;
	typedef logic [$clog2(num_units)-1:0] unit_idx_t;
	typedef logic [4:0]                   opcode_t;

	typedef enum logic {
		op_add,
		op_sub
	} alu_op_t;

	// waiting = issued, operands not read yet
	typedef enum logic [1:0] {
		unit_free,
		unit_waiting,
		unit_working
	} unit_state_t;

	////////////////////////////////
	// instruction encoding
	////////////////////////////////
	localparam opcode_t opc_addi = 5'd0;
	localparam opcode_t opc_add  = 5'd1;
	localparam opcode_t opc_subi = 5'd2;
	localparam opcode_t opc_sub  = 5'd3;

	localparam int opc_hi   = 15;
	localparam int opc_lo   = 11;
	localparam int dest_hi  = 10;
	localparam int dest_lo  = 8;
	localparam int src_a_hi = 7;
	localparam int src_a_lo = 5;
	localparam int src_b_hi = 2;
	localparam int src_b_lo = 0;
	localparam int imm_hi   = 4;
	localparam int imm_lo   = 0;
	localparam int imm_w    = imm_hi - imm_lo + 1;

endpackage

/* src/scoreboard.sv */
`timescale 1ns/10ps

module scoreboard import sb_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 dec_valid,
	input  alu_op_t              dec_op,
	input  reg_idx_t             dec_dest,
	input  reg_idx_t             dec_src_a,
	input  reg_idx_t             dec_src_b,
	input  logic                 dec_use_imm,
	input  word_t                dec_imm,
	input  logic [num_units-1:0] wb_valid,
	input  word_t                rd_data_a_0,
	input  word_t                rd_data_b_0,
	input  word_t                rd_data_a_1,
	input  word_t                rd_data_b_1,
	output logic                 issue,
	output logic [num_units-1:0] disp_valid,
	output alu_op_t              disp_op_0,
	output alu_op_t              disp_op_1,
	output reg_idx_t             disp_dest_0,
	output reg_idx_t             disp_dest_1,
	output reg_idx_t             rd_addr_a_0,
	output reg_idx_t             rd_addr_b_0,
	output reg_idx_t             rd_addr_a_1,
	output reg_idx_t             rd_addr_b_1,
	output word_t                opnd_a_0,
	output word_t                opnd_b_0,
	output word_t                opnd_a_1,
	output word_t                opnd_b_1,
	output logic                 idle
);

	// register status: pending writer and which unit it is
	logic [num_regs-1:0] reg_busy;
	unit_idx_t           reg_tag [num_regs];

	// unit status
	unit_state_t st      [num_units];
	alu_op_t     op      [num_units];
	reg_idx_t    dest    [num_units];
	reg_idx_t    src_a   [num_units];
	reg_idx_t    src_b   [num_units];
	unit_idx_t   tag_a   [num_units];
	unit_idx_t   tag_b   [num_units];
	logic        rdy_a   [num_units];
	logic        rdy_b   [num_units];
	logic        use_imm [num_units];
	word_t       imm     [num_units];

	unit_idx_t sel;
	logic      unit_avail;
	logic      war_hazard;
	logic      src_a_now;
	logic      src_b_now;

	////////////////////////////////
	// issue
	////////////////////////////////
	assign unit_avail = (st[0] == unit_free) || (st[1] == unit_free);
	assign sel        = (st[0] == unit_free) ? unit_idx_t'(0) : unit_idx_t'(1);

	// a waiting unit has not read its sources yet
	always_comb begin
		war_hazard = 1'b0;
		for (int u = 0; u < num_units; u++) begin
			if (st[u] == unit_waiting) begin
				if (src_a[u] == dec_dest)
					war_hazard = 1'b1;
				if (!use_imm[u] && src_b[u] == dec_dest)
					war_hazard = 1'b1;
			end
		end
	end

	assign issue = dec_valid && unit_avail && !reg_busy[dec_dest] && !war_hazard;

	// producer may be finishing right now
	assign src_a_now = !reg_busy[dec_src_a] || wb_valid[reg_tag[dec_src_a]];
	assign src_b_now = !reg_busy[dec_src_b] || wb_valid[reg_tag[dec_src_b]];

	////////////////////////////////
	// dispatch
	////////////////////////////////
	always_comb begin
		for (int u = 0; u < num_units; u++) begin
			disp_valid[u] = (st[u] == unit_waiting) && rdy_a[u] && rdy_b[u];
		end
	end

	assign disp_op_0   = op[0];
	assign disp_op_1   = op[1];
	assign disp_dest_0 = dest[0];
	assign disp_dest_1 = dest[1];
	assign rd_addr_a_0 = src_a[0];
	assign rd_addr_b_0 = src_b[0];
	assign rd_addr_a_1 = src_a[1];
	assign rd_addr_b_1 = src_b[1];
	assign opnd_a_0    = rd_data_a_0;
	assign opnd_a_1    = rd_data_a_1;
	assign opnd_b_0    = use_imm[0] ? imm[0] : rd_data_b_0;
	assign opnd_b_1    = use_imm[1] ? imm[1] : rd_data_b_1;

	assign idle = !dec_valid && (st[0] == unit_free) && (st[1] == unit_free);

	////////////////////////////////
	// state update
	////////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			reg_busy <= '0;
			for (int u = 0; u < num_units; u++) begin
				st[u]    <= unit_free;
				rdy_a[u] <= 1'b0;
				rdy_b[u] <= 1'b0;
			end
		end else begin
			for (int u = 0; u < num_units; u++) begin
				if (wb_valid[u]) begin
					st[u]             <= unit_free;
					reg_busy[dest[u]] <= 1'b0;
				end else if (disp_valid[u]) begin
					st[u] <= unit_working;
				end
				// wake sources waiting on a completing unit
				if (st[u] == unit_waiting) begin
					if (!rdy_a[u] && wb_valid[tag_a[u]])
						rdy_a[u] <= 1'b1;
					if (!rdy_b[u] && wb_valid[tag_b[u]])
						rdy_b[u] <= 1'b1;
				end
			end
			if (issue) begin
				st[sel]            <= unit_waiting;
				reg_busy[dec_dest] <= 1'b1;
				rdy_a[sel]         <= src_a_now;
				rdy_b[sel]         <= dec_use_imm || src_b_now;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			op[sel]           <= dec_op;
			dest[sel]         <= dec_dest;
			src_a[sel]        <= dec_src_a;
			src_b[sel]        <= dec_src_b;
			use_imm[sel]      <= dec_use_imm;
			imm[sel]          <= dec_imm;
			tag_a[sel]        <= reg_tag[dec_src_a];
			tag_b[sel]        <= reg_tag[dec_src_b];
			reg_tag[dec_dest] <= sel;
		end
	end

endmodule
